// ==== files.f ====
hdl/uartPkg.sv
hdl/uartWbRegs.sv
hdl/uartTxFifo.sv
hdl/uartBaudTimer.sv
hdl/uartTxFsm.sv
hdl/uartTxTop.sv
verification/uartLineMonitor.sv
verification/uartTxTb.sv

// ==== Bender.yml ====
package:
  name: uart_tx

sources:
  - hdl/uartPkg.sv
  - hdl/uartWbRegs.sv
  - hdl/uartTxFifo.sv
  - hdl/uartBaudTimer.sv
  - hdl/uartTxFsm.sv
  - hdl/uartTxTop.sv
  - target: simulation
    files:
      - verification/uartLineMonitor.sv
      - verification/uartTxTb.sv

// ==== verification/uartTxTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTxTb
    import uartPkg::*;
();

    logic       clk;
    logic       reset;
    logic       cyc;
    logic       stb;
    logic       we;
    wbAddrT     adr;
    logic [3:0] sel;
    wbDataT     datIn;
    wbDataT     datOut;
    logic       ack;
    logic       txLine;
    baudDivT    lineDiv;  // divisor the monitor decodes with
    logic       rxValid;
    byteT       rxByte;
    logic       rxGap;
    logic       frameErr;

    byteT expQ[$];
    bit   backQ[$];  // frame must follow the previous stop bit directly
    int   errCount;
    int   errBefore;
    int   testCount;
    int   failCount;
    int   rxCount;

    uartTxTop dut0 (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel),
        .datIn(datIn), .datOut(datOut), .ack(ack), .txLine(txLine)
    );

    uartLineMonitor mon0 (
        .clk(clk), .reset(reset), .txLine(txLine), .baudDiv(lineDiv),
        .rxValid(rxValid), .rxByte(rxByte), .rxGap(rxGap), .frameErr(frameErr)
    );

    always #20 clk = ~clk;

    ackHasRequest: assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb))
        else begin
            $display("ack without a bus request at %0t", $time);
            errCount++;
        end

    // scoreboard, monitor outputs change on negedge
    always @(posedge clk) begin
        if (rxValid) begin
            rxCount++;
            assert (expQ.size() > 0) else begin
                $display("unexpected frame 0x%02h on the line at %0t", rxByte, $time);
                errCount++;
            end
            if (expQ.size() > 0) begin
                assert (rxByte == expQ[0]) else begin
                    $display("MISMATCH at %0t: rxByte got 0x%02h expected 0x%02h",
                             $time, rxByte, expQ[0]);
                    errCount++;
                end
                assert (!(backQ[0] && rxGap)) else begin
                    $display("idle gap before frame 0x%02h at %0t", rxByte, $time);
                    errCount++;
                end
                void'(expQ.pop_front());
                void'(backQ.pop_front());
            end
        end
        assert (frameErr !== 1'b1) else begin
            $display("bad start or stop bit on the line at %0t", $time);
            errCount++;
        end
    end

    task automatic abortRun(input string reason);
        $display("run aborted: %s", reason);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic compareWord(input string name, input wbDataT got, input wbDataT exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            errCount++;
        end
    endtask

    // one classic cycle, called on a falling edge and returns on one
    task automatic busCycle(input logic write, input wbAddrT addr, input wbDataT data,
                            input logic [3:0] selMask, output wbDataT rd);
        int waited;
        waited = 0;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        sel    = selMask;
        datIn  = data;
        @(negedge clk);
        while (!ack) begin
            waited++;
            if (waited > 20) abortRun("bus cycle got no ack");
            @(negedge clk);
        end
        rd  = datOut;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic sendByte(input byteT b, input bit backToBack);
        wbDataT unused;
        expQ.push_back(b);
        backQ.push_back(backToBack);
        busCycle(1'b1, RegTxData, {24'h0, b}, 4'b0001, unused);
    endtask

    task automatic waitStatus(input logic [3:0] mask, input logic [3:0] want,
                              input int maxReads, input string what);
        wbDataT rd;
        int     reads;
        bit     seen;
        seen  = 1'b0;
        reads = 0;
        while (!seen && reads < maxReads) begin
            busCycle(1'b0, RegStatus, '0, 4'hF, rd);
            seen = ((rd[3:0] & mask) == want);
            reads++;
        end
        assert (seen) else begin
            $display("status never showed %s", what);
            errCount++;
        end
    endtask

    task automatic waitFramesDone(input int maxCycles);
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            if (waited >= maxCycles) abortRun("expected frames never appeared on the line");
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errCount == errBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failCount++;
            $display("test %0d %s: %0d errors", testCount, name, errCount - errBefore);
        end
        errBefore = errCount;
    endtask

    initial begin
        wbDataT  rd;
        baudDivT expDiv;
        byteT    b;
        int      i;
        int      seenBefore;
        clk       = 1'b0;
        reset     = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        sel       = '0;
        datIn     = '0;
        lineDiv   = BaudDivReset;
        errCount  = 0;
        errBefore = 0;
        testCount = 0;
        failCount = 0;
        rxCount   = 0;
        void'($urandom(95));
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (i = 0; i < 2 * (BaudDivReset + 1); i++) begin
            assert (txLine === 1'b0 && ack === 1'b0) else begin
                $display("line or ack active after reset at %0t", $time);
                errCount++;
            end
            @(negedge clk);
        end
        busCycle(1'b0, RegStatus, '0, 4'hF, rd);
        compareWord("status", rd, 32'h2);  // empty only
        busCycle(1'b0, RegBaudDiv, '0, 4'hF, rd);
        compareWord("baudDiv", rd, {16'h0, BaudDivReset});
        endTest("reset state");

        expDiv = {BaudDivReset[15:8], 8'hC3};
        busCycle(1'b1, RegBaudDiv, 32'hFFFF_A5C3, 4'b0001, rd);
        busCycle(1'b0, RegBaudDiv, '0, 4'hF, rd);
        compareWord("baudDiv lane 0", rd, {16'h0, expDiv});
        expDiv = {8'h02, expDiv[7:0]};
        busCycle(1'b1, RegBaudDiv, 32'hDEAD_02FF, 4'b0010, rd);
        busCycle(1'b0, RegBaudDiv, '0, 4'hF, rd);
        compareWord("baudDiv lane 1", rd, {16'h0, expDiv});
        endTest("divisor byte lanes");

        busCycle(1'b1, RegBaudDiv, 32'd7, 4'b0011, rd);
        lineDiv = 16'd7;
        sendByte(byteT'($urandom), 1'b0);
        waitStatus(4'b0100, 4'b0100, 1000, "busy during the frame");
        waitFramesDone(20000);
        waitStatus(4'b0100, 4'b0000, 200, "not busy after the frame");
        endTest("single frame");

        for (i = 0; i < FifoDepth; i++) sendByte(byteT'($urandom), i != 0);
        waitFramesDone(20000);
        waitStatus(4'b0110, 4'b0010, 200, "idle and empty after the burst");
        endTest("back to back burst");

        busCycle(1'b1, RegBaudDiv, 32'd20, 4'b0011, rd);
        lineDiv = 16'd20;
        sendByte(byteT'($urandom), 1'b0);
        waitStatus(4'b0100, 4'b0100, 1000, "busy before the overrun burst");
        for (i = 0; i < FifoDepth + 1; i++) begin
            b = byteT'($urandom);
            if (i < FifoDepth) sendByte(b, 1'b1);
            else busCycle(1'b1, RegTxData, {24'h0, b}, 4'b0001, rd);  // dropped
        end
        busCycle(1'b0, RegStatus, '0, 4'hF, rd);
        compareWord("status overrun and full", rd & 32'h9, 32'h9);
        busCycle(1'b0, RegStatus, '0, 4'hF, rd);
        compareWord("status overrun after read", rd & 32'h8, 32'h0);
        waitFramesDone(20000);
        waitStatus(4'b0110, 4'b0010, 400, "idle and empty after the overrun");
        endTest("overrun");

        seenBefore = rxCount;
        busCycle(1'b1, 4'hC, 32'h0000_0055, 4'b1111, rd);
        busCycle(1'b0, 4'hC, '0, 4'hF, rd);
        compareWord("unmapped read", rd, 32'h0);
        for (i = 0; i < 12 * (lineDiv + 1); i++) begin
            assert (txLine === 1'b0) else begin
                $display("line active after an unmapped write at %0t", $time);
                errCount++;
            end
            @(negedge clk);
        end
        assert (rxCount == seenBefore) else begin
            $display("a frame appeared after an unmapped write");
            errCount++;
        end
        endTest("unmapped offset");

        $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/uartLineMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartLineMonitor
    import uartPkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    txLine,
    input  wire baudDivT baudDiv,
    output logic         rxValid,   // one cycle per decoded frame
    output byteT         rxByte,
    output logic         rxGap,     // idle time before this frame
    output logic         frameErr
);

    int   now;
    int   startAt;
    int   stopAt;
    int   period;
    int   offset;
    logic inFrame;
    logic gapSeen;
    byteT shifter;

    // negedge sampling, offsets counted from the first cycle the start bit is seen
    always @(negedge clk) begin
        rxValid  = 1'b0;
        frameErr = 1'b0;
        now      = now + 1;
        if (reset) begin
            now     = 0;
            inFrame = 1'b0;
            stopAt  = -1000000;  // first frame is always after idle
            rxGap   = 1'b0;
            rxByte  = '0;
        end else if (!inFrame) begin
            if (txLine === 1'b1) begin
                inFrame = 1'b1;
                startAt = now;
                period  = int'(baudDiv) + 1;
                gapSeen = (startAt - stopAt) > period;
            end
        end else begin
            offset = now - startAt;
            if (offset == period / 2) begin
                if (txLine !== 1'b1) frameErr = 1'b1;  // start bit too short
            end else if (offset > period && offset < 9 * period &&
                         (offset % period) == period / 2) begin
                shifter = {txLine, shifter[7:1]};  // LSB first
            end else if (offset == 9 * period + period / 2) begin
                if (txLine !== 1'b0) frameErr = 1'b1;
                rxByte  = shifter;
                rxGap   = gapSeen;
                rxValid = 1'b1;
                stopAt  = startAt + 9 * period;
                inFrame = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uartTxTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTxTop
    import uartPkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       cyc,
    input  wire logic       stb,
    input  wire logic       we,
    input  wire wbAddrT     adr,
    input  wire logic [3:0] sel,
    input  wire wbDataT     datIn,
    output wbDataT          datOut,
    output logic            ack,
    output logic            txLine
);

    logic    push;
    byteT    wrData;
    baudDivT baudDiv;
    byteT    rdData;
    logic    fifoFull;
    logic    fifoEmpty;
    logic    pop;
    logic    tick;
    logic    txBusy;

    uartWbRegs regs0 (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .datIn(datIn),
        .fifoFull(fifoFull), .fifoEmpty(fifoEmpty), .txBusy(txBusy),
        .datOut(datOut), .ack(ack),
        .push(push), .wrData(wrData), .baudDiv(baudDiv)
    );

    uartTxFifo fifo0 (
        .clk(clk), .reset(reset),
        .push(push), .wrData(wrData), .pop(pop),
        .rdData(rdData), .full(fifoFull), .empty(fifoEmpty)
    );

    uartBaudTimer timer0 (
        .clk(clk), .reset(reset),
        .baudDiv(baudDiv), .tick(tick)
    );

    uartTxFsm fsm0 (
        .clk(clk), .reset(reset),
        .tick(tick), .rdData(rdData), .empty(fifoEmpty),
        .pop(pop), .txBusy(txBusy), .txLine(txLine)
    );

endmodule

`default_nettype wire

// ==== hdl/uartTxFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTxFsm
    import uartPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic tick,
    input  wire byteT rdData,
    input  wire logic empty,
    output logic      pop,
    output logic      txBusy,
    output logic      txLine
);

    txStateT    state;
    byteT       shiftReg;
    logic [2:0] bitCnt;
    logic       loadNext;  // start a frame on this tick

    assign loadNext = (state == TxIdle || state == TxStop) && !empty;
    assign pop      = tick && loadNext;
    assign txBusy   = (state != TxIdle);

    // line idles low, start bit high, stop bit low
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= TxIdle;
            bitCnt <= '0;
            txLine <= 1'b0;
        end else if (tick) begin
            case (state)
                TxIdle, TxStop: begin
                    if (loadNext) begin
                        state  <= TxStart;
                        bitCnt <= 3'd7;
                        txLine <= 1'b1;
                    end else begin
                        state  <= TxIdle;
                        txLine <= 1'b0;
                    end
                end
                TxStart: begin
                    state  <= TxData;
                    txLine <= shiftReg[0];  // bit 0 goes out here
                end
                TxData: begin
                    if (bitCnt == 0) begin
                        state  <= TxStop;
                        txLine <= 1'b0;
                    end else begin
                        txLine <= shiftReg[0];
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                default: begin
                    state  <= TxIdle;
                    txLine <= 1'b0;
                end
            endcase
        end
    end

    // data path, shifts LSB first
    always_ff @(posedge clk) begin
        if (pop) begin
            shiftReg <= rdData;
        end else if (tick && (state == TxStart || (state == TxData && bitCnt != 0))) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

    // a load lands on a bit boundary and starts the frame on the next edge
    popOnTick: assert property (@(posedge clk) disable iff (reset)
        pop |-> tick ##1 (state == TxStart && txLine))
        else $error("pop outside a tick cycle or frame not started");

endmodule

`default_nettype wire

// ==== hdl/uartBaudTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartBaudTimer
    import uartPkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire baudDivT baudDiv,
    output logic         tick
);

    baudDivT baudCount;

    // one cycle at zero, then reload
    assign tick = (baudCount == '0);

    // divisor changes are picked up only at reload
    always_ff @(posedge clk) begin
        if (reset) begin
            baudCount <= BaudDivReset;
        end else if (tick) begin
            baudCount <= baudDiv;
        end else begin
            baudCount <= baudCount - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uartTxFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTxFifo
    import uartPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic push,
    input  wire byteT wrData,
    input  wire logic pop,
    output byteT      rdData,
    output logic      full,
    output logic      empty
);

    byteT                    mem [FifoDepth];
    logic [FifoPtrWidth-1:0] wrPtr;
    logic [FifoPtrWidth-1:0] rdPtr;
    logic [FifoPtrWidth:0]   count;  // one extra bit to tell full from empty

    assign full   = (count == FifoDepth);
    assign empty  = (count == 0);
    assign rdData = mem[rdPtr];  // head byte, valid when not empty

    always_ff @(posedge clk) begin
        if (push) mem[wrPtr] <= wrData;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
        end else if (push) begin
            wrPtr <= wrPtr + 1'b1;  // wraps at depth
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr <= '0;
        end else if (pop) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // push and pop together leave the count alone
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the register block must hold back writes when full
    noPushFull: assert property (@(posedge clk) disable iff (reset) full |-> !push)
        else $error("push while FIFO full");

    // the state machine must only load when a byte waits
    noPopEmpty: assert property (@(posedge clk) disable iff (reset) empty |-> !pop)
        else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// ==== hdl/uartWbRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartWbRegs
    import uartPkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    cyc,
    input  wire logic    stb,
    input  wire logic    we,
    input  wire wbAddrT  adr,
    input  wire logic [3:0] sel,
    input  wire wbDataT  datIn,
    input  wire logic    fifoFull,
    input  wire logic    fifoEmpty,
    input  wire logic    txBusy,
    output wbDataT       datOut,
    output logic         ack,
    output logic         push,
    output byteT         wrData,
    output baudDivT      baudDiv
);

    logic   accept;     // new classic cycle seen on this edge
    logic   wrAccept;
    logic   rdAccept;
    logic   txWrite;    // write to the data register on lane 0
    logic   overrun;
    wbDataT rdMux;

    assign accept   = cyc && stb && !ack;
    assign wrAccept = accept && we;
    assign rdAccept = accept && !we;
    assign txWrite  = wrAccept && (adr == RegTxData) && sel[0];

    // single cycle ack, a held stb gets every second cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // divisor, one byte lane at a time
    always_ff @(posedge clk) begin
        if (reset) begin
            baudDiv <= BaudDivReset;
        end else if (wrAccept && adr == RegBaudDiv) begin
            if (sel[0]) baudDiv[7:0]  <= datIn[7:0];
            if (sel[1]) baudDiv[15:8] <= datIn[15:8];
        end
    end

    // push lines up with the ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= txWrite && !fifoFull;
        end
    end

    always_ff @(posedge clk) begin
        if (txWrite) wrData <= datIn[7:0];
    end

    // sticky until a status read
    always_ff @(posedge clk) begin
        if (reset) begin
            overrun <= 1'b0;
        end else if (rdAccept && adr == RegStatus) begin
            overrun <= 1'b0;
        end else if (txWrite && fifoFull) begin
            overrun <= 1'b1;  // byte is dropped
        end
    end

    always_comb begin
        case (adr)
            RegBaudDiv: rdMux = {16'h0, baudDiv};
            RegStatus:  rdMux = {28'h0, overrun, txBusy, fifoEmpty, fifoFull};
            default:    rdMux = '0;  // data register and unmapped offsets
        endcase
    end

    // read data held through the ack cycle
    always_ff @(posedge clk) begin
        if (accept) datOut <= rdMux;
    end

    ackSingle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== hdl/uartPkg.sv ====
`default_nettype none

package uartPkg;

    // one transmit character
    typedef logic [7:0] byteT;

    // bit period is baudDiv + 1 clocks
    typedef logic [15:0] baudDivT;

    typedef logic [31:0] wbDataT;

    // byte address inside the peripheral
    typedef logic [3:0] wbAddrT;

    // register offsets
    localparam wbAddrT RegTxData  = 4'h0;  // write pushes a byte, read gives zero
    localparam wbAddrT RegBaudDiv = 4'h4;  // lanes 0 and 1 only
    localparam wbAddrT RegStatus  = 4'h8;  // {overrun, txBusy, fifoEmpty, fifoFull}

    // transmit FIFO
    localparam int FifoDepth    = 4;
    localparam int FifoPtrWidth = 2;

    // divisor after reset, 5 clocks per bit
    localparam baudDivT BaudDivReset = 16'd4;

    // frame sequencer states
    typedef enum logic [1:0] {
        TxIdle,
        TxStart,
        TxData,
        TxStop
    } txStateT;

endpackage

`default_nettype wire
